// File: files.f
+incdir+hdl
hdl/bru_pkg.sv
hdl/bru_decode_stage.sv
hdl/bru_cond_unit.sv
hdl/bru_target_unit.sv
hdl/bru_resolve.sv
hdl/bru_pipe.sv
verif/bru_tb.sv

// File: hdl/bru_cfg.svh
// Width settings for the branch execution pipeline
// Included by the package and by any module that slices on raw widths

`ifndef BRU_CFG_SVH
`define BRU_CFG_SVH

// ---------------------------------------------------------------------------
// Datapath widths
// ---------------------------------------------------------------------------

// Integer register width (RV64)
`define BRU_XLEN 64

// Sv39 virtual address
`define BRU_VADDR_W 39

// Expanded instruction word
`define BRU_INST_W 32

// Architectural register index
`define BRU_REGIDX_W 5

`endif

// File: hdl/bru_cond_unit.sv
`timescale 1ns/1ps
// Branch condition evaluation in ex1
// Compares the two operands as the op selects and registers taken into ex2

module bru_cond_unit (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  bru_pkg::br_op_t  i_ex1_op,
  input  bru_pkg::xlen_t   i_ex1_rs1_data,
  input  bru_pkg::xlen_t   i_ex1_rs2_data,
  output logic             o_ex2_taken
);
  import bru_pkg::*;

  logic is_eq;
  logic is_lt;
  logic is_ltu;
  logic taken;

  // Shared compare results
  assign is_eq  = (i_ex1_rs1_data == i_ex1_rs2_data);
  assign is_lt  = ($signed(i_ex1_rs1_data) < $signed(i_ex1_rs2_data));
  assign is_ltu = (i_ex1_rs1_data < i_ex1_rs2_data);

  always_comb begin
    case (i_ex1_op)
      OP_EQ:   taken = is_eq;
      OP_NE:   taken = !is_eq;
      OP_LT:   taken = is_lt;
      OP_GE:   taken = !is_lt;
      OP_LTU:  taken = is_ltu;
      OP_GEU:  taken = !is_ltu;
      OP_JUMP: taken = 1'b1;   // Unconditional
      default: taken = 1'b0;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Ex2 register
  // ---------------------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_taken <= 1'b0;
    end else begin
      o_ex2_taken <= taken;
    end
  end

endmodule

// File: hdl/bru_decode_stage.sv
`timescale 1ns/1ps
// Branch decode stage, one issue per cycle
// Decodes opcode and funct3, then registers control and operands into ex1

module bru_decode_stage (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_issue_valid,
  input  bru_pkg::vaddr_t       i_issue_pc,
  input  bru_pkg::inst_t        i_issue_inst,
  input  logic                  i_issue_is_rvc,
  input  bru_pkg::xlen_t        i_issue_rs1_data,
  input  bru_pkg::xlen_t        i_issue_rs2_data,
  input  logic                  i_issue_pred_taken,
  input  bru_pkg::vaddr_t       i_issue_pred_target,
  output logic                  o_ex1_valid,
  output bru_pkg::br_op_t       o_ex1_op,
  output bru_pkg::imm_kind_t    o_ex1_imm_kind,
  output logic                  o_ex1_is_cond,
  output logic                  o_ex1_wr_rd,
  output bru_pkg::regidx_t      o_ex1_rd,
  output bru_pkg::vaddr_t       o_ex1_pc,
  output bru_pkg::inst_t        o_ex1_inst,
  output logic                  o_ex1_is_rvc,
  output bru_pkg::xlen_t        o_ex1_rs1_data,
  output bru_pkg::xlen_t        o_ex1_rs2_data,
  output logic                  o_ex1_pred_taken,
  output bru_pkg::vaddr_t       o_ex1_pred_target
);
  import bru_pkg::*;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  br_op_t     dec_op;
  imm_kind_t  dec_imm_kind;
  logic       dec_is_cond;
  logic       dec_wr_rd;

  assign opcode = i_issue_inst[6:0];
  assign funct3 = i_issue_inst[14:12];

  always_comb begin
    dec_op       = OP_JUMP;
    dec_imm_kind = IMM_NONE;
    dec_is_cond  = 1'b0;
    dec_wr_rd    = 1'b0;
    case (opcode)
      OPC_JAL: begin
        dec_imm_kind = IMM_UJ;
        dec_wr_rd    = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin  // Other funct3 values are reserved
          dec_imm_kind = IMM_I;
          dec_wr_rd    = 1'b1;
        end
      end
      OPC_BRANCH: begin
        dec_imm_kind = IMM_SB;
        dec_is_cond  = 1'b1;
        case (funct3)
          3'b000:  dec_op = OP_EQ;
          3'b001:  dec_op = OP_NE;
          3'b100:  dec_op = OP_LT;
          3'b101:  dec_op = OP_GE;
          3'b110:  dec_op = OP_LTU;
          3'b111:  dec_op = OP_GEU;
          default: dec_imm_kind = IMM_NONE;
        endcase
      end
      default: dec_imm_kind = IMM_NONE;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Ex1 registers
  // ---------------------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex1_valid <= 1'b0;
    end else begin
      o_ex1_valid <= i_issue_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex1_op          <= dec_op;
    o_ex1_imm_kind    <= dec_imm_kind;
    o_ex1_is_cond     <= dec_is_cond;
    o_ex1_wr_rd       <= dec_wr_rd;
    o_ex1_rd          <= i_issue_inst[11:7];
    o_ex1_pc          <= i_issue_pc;
    o_ex1_inst        <= i_issue_inst;
    o_ex1_is_rvc      <= i_issue_is_rvc;
    o_ex1_rs1_data    <= i_issue_rs1_data;
    o_ex1_rs2_data    <= i_issue_rs2_data;
    o_ex1_pred_taken  <= i_issue_pred_taken;
    o_ex1_pred_target <= i_issue_pred_target;
  end

  // The scheduler only issues branches and jumps here
  a_issue_is_branch: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |=> (o_ex1_valid && o_ex1_imm_kind != IMM_NONE))
    else $error("non-branch instruction %h issued to branch unit", o_ex1_inst);

endmodule

// File: hdl/bru_pipe.sv
`timescale 1ns/1ps
// Top of the branch execution pipeline
// Decode into ex1, condition and target side by side into ex2, then resolve

module bru_pipe (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_issue_valid,
  input  bru_pkg::vaddr_t   i_issue_pc,
  input  bru_pkg::inst_t    i_issue_inst,
  input  logic              i_issue_is_rvc,
  input  bru_pkg::xlen_t    i_issue_rs1_data,
  input  bru_pkg::xlen_t    i_issue_rs2_data,
  input  logic              i_issue_pred_taken,
  input  bru_pkg::vaddr_t   i_issue_pred_target,
  output logic              o_upd_valid,
  output bru_pkg::vaddr_t   o_upd_pc,
  output logic              o_upd_is_cond,
  output logic              o_upd_taken,
  output bru_pkg::vaddr_t   o_upd_target,
  output logic              o_upd_mispredict,
  output logic              o_wr_valid,
  output bru_pkg::regidx_t  o_wr_rd,
  output bru_pkg::xlen_t    o_wr_data
);
  import bru_pkg::*;

  // Ex1 bundle
  logic      ex1_valid;
  br_op_t    ex1_op;
  imm_kind_t ex1_imm_kind;
  logic      ex1_is_cond;
  logic      ex1_wr_rd;
  regidx_t   ex1_rd;
  vaddr_t    ex1_pc;
  inst_t     ex1_inst;
  logic      ex1_is_rvc;
  xlen_t     ex1_rs1_data;
  xlen_t     ex1_rs2_data;
  logic      ex1_pred_taken;
  vaddr_t    ex1_pred_target;

  // Ex2 bundle
  logic      ex2_taken;
  logic      ex2_valid;
  vaddr_t    ex2_target;
  xlen_t     ex2_link_data;
  vaddr_t    ex2_pc;
  logic      ex2_is_rvc;
  logic      ex2_is_cond;
  logic      ex2_wr_valid;
  regidx_t   ex2_rd;
  logic      ex2_pred_taken;
  vaddr_t    ex2_pred_target;

  bru_decode_stage u_decode (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_issue_valid       (i_issue_valid),
    .i_issue_pc          (i_issue_pc),
    .i_issue_inst        (i_issue_inst),
    .i_issue_is_rvc      (i_issue_is_rvc),
    .i_issue_rs1_data    (i_issue_rs1_data),
    .i_issue_rs2_data    (i_issue_rs2_data),
    .i_issue_pred_taken  (i_issue_pred_taken),
    .i_issue_pred_target (i_issue_pred_target),
    .o_ex1_valid         (ex1_valid),
    .o_ex1_op            (ex1_op),
    .o_ex1_imm_kind      (ex1_imm_kind),
    .o_ex1_is_cond       (ex1_is_cond),
    .o_ex1_wr_rd         (ex1_wr_rd),
    .o_ex1_rd            (ex1_rd),
    .o_ex1_pc            (ex1_pc),
    .o_ex1_inst          (ex1_inst),
    .o_ex1_is_rvc        (ex1_is_rvc),
    .o_ex1_rs1_data      (ex1_rs1_data),
    .o_ex1_rs2_data      (ex1_rs2_data),
    .o_ex1_pred_taken    (ex1_pred_taken),
    .o_ex1_pred_target   (ex1_pred_target)
  );

  bru_cond_unit u_cond (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex1_op       (ex1_op),
    .i_ex1_rs1_data (ex1_rs1_data),
    .i_ex1_rs2_data (ex1_rs2_data),
    .o_ex2_taken    (ex2_taken)
  );

  bru_target_unit u_target (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_ex1_valid       (ex1_valid),
    .i_ex1_imm_kind    (ex1_imm_kind),
    .i_ex1_is_cond     (ex1_is_cond),
    .i_ex1_wr_rd       (ex1_wr_rd),
    .i_ex1_rd          (ex1_rd),
    .i_ex1_pc          (ex1_pc),
    .i_ex1_inst        (ex1_inst),
    .i_ex1_is_rvc      (ex1_is_rvc),
    .i_ex1_rs1_data    (ex1_rs1_data),
    .i_ex1_pred_taken  (ex1_pred_taken),
    .i_ex1_pred_target (ex1_pred_target),
    .o_ex2_valid       (ex2_valid),
    .o_ex2_target      (ex2_target),
    .o_ex2_link_data   (ex2_link_data),
    .o_ex2_pc          (ex2_pc),
    .o_ex2_is_rvc      (ex2_is_rvc),
    .o_ex2_is_cond     (ex2_is_cond),
    .o_ex2_wr_valid    (ex2_wr_valid),
    .o_ex2_rd          (ex2_rd),
    .o_ex2_pred_taken  (ex2_pred_taken),
    .o_ex2_pred_target (ex2_pred_target)
  );

  bru_resolve u_resolve (
    .i_ex2_taken       (ex2_taken),
    .i_ex2_valid       (ex2_valid),
    .i_ex2_target      (ex2_target),
    .i_ex2_link_data   (ex2_link_data),
    .i_ex2_pc          (ex2_pc),
    .i_ex2_is_rvc      (ex2_is_rvc),
    .i_ex2_is_cond     (ex2_is_cond),
    .i_ex2_wr_valid    (ex2_wr_valid),
    .i_ex2_rd          (ex2_rd),
    .i_ex2_pred_taken  (ex2_pred_taken),
    .i_ex2_pred_target (ex2_pred_target),
    .o_upd_valid       (o_upd_valid),
    .o_upd_pc          (o_upd_pc),
    .o_upd_is_cond     (o_upd_is_cond),
    .o_upd_taken       (o_upd_taken),
    .o_upd_target      (o_upd_target),
    .o_upd_mispredict  (o_upd_mispredict),
    .o_wr_valid        (o_wr_valid),
    .o_wr_rd           (o_wr_rd),
    .o_wr_data         (o_wr_data)
  );

endmodule

// File: hdl/bru_pkg.sv
// Shared types of the branch execution pipeline
// Widths come from the cfg header, enums name the branch op and immediate form

`include "bru_cfg.svh"

package bru_pkg;

  // -------------------------------------------------------------------------
  // Vector types
  // -------------------------------------------------------------------------

  typedef logic [`BRU_XLEN-1:0]     xlen_t;    // Register value
  typedef logic [`BRU_VADDR_W-1:0]  vaddr_t;   // Virtual address
  typedef logic [`BRU_INST_W-1:0]   inst_t;    // Raw instruction
  typedef logic [`BRU_REGIDX_W-1:0] regidx_t;  // Destination register

  // -------------------------------------------------------------------------
  // Decoded control
  // -------------------------------------------------------------------------

  // Branch compare operation, funct3 order for the conditional ones
  typedef enum logic [2:0] {
    OP_EQ,
    OP_NE,
    OP_LT,
    OP_GE,
    OP_LTU,
    OP_GEU,
    OP_JUMP    // JAL and JALR, always taken
  } br_op_t;

  // Immediate layout used for the target
  typedef enum logic [1:0] {
    IMM_SB,    // Conditional branch, pc relative
    IMM_UJ,    // JAL, pc relative
    IMM_I,     // JALR, rs1 relative
    IMM_NONE   // Not a branch
  } imm_kind_t;

endpackage

// File: hdl/bru_resolve.sv
`timescale 1ns/1ps
// Branch resolution in ex2, purely combinational
// Picks the update target, flags a mispredict and drives the link write-back

module bru_resolve (
  input  logic              i_ex2_taken,
  input  logic              i_ex2_valid,
  input  bru_pkg::vaddr_t   i_ex2_target,
  input  bru_pkg::xlen_t    i_ex2_link_data,
  input  bru_pkg::vaddr_t   i_ex2_pc,
  input  logic              i_ex2_is_rvc,
  input  logic              i_ex2_is_cond,
  input  logic              i_ex2_wr_valid,
  input  bru_pkg::regidx_t  i_ex2_rd,
  input  logic              i_ex2_pred_taken,
  input  bru_pkg::vaddr_t   i_ex2_pred_target,
  output logic              o_upd_valid,
  output bru_pkg::vaddr_t   o_upd_pc,
  output logic              o_upd_is_cond,
  output logic              o_upd_taken,
  output bru_pkg::vaddr_t   o_upd_target,
  output logic              o_upd_mispredict,
  output logic              o_wr_valid,
  output bru_pkg::regidx_t  o_wr_rd,
  output bru_pkg::xlen_t    o_wr_data
);
  import bru_pkg::*;

  vaddr_t fall_through;
  logic   dir_miss;
  logic   tgt_miss;

  assign fall_through = i_ex2_pc + (i_ex2_is_rvc ? vaddr_t'(2) : vaddr_t'(4));

  // ---------------------------------------------------------------------------
  // Branch update
  // ---------------------------------------------------------------------------

  assign dir_miss = (i_ex2_taken != i_ex2_pred_taken);
  assign tgt_miss = i_ex2_taken && i_ex2_pred_taken && (i_ex2_target != i_ex2_pred_target);

  assign o_upd_valid      = i_ex2_valid;
  assign o_upd_pc         = i_ex2_pc;
  assign o_upd_is_cond    = i_ex2_is_cond;
  assign o_upd_taken      = i_ex2_taken;
  assign o_upd_target     = i_ex2_taken ? i_ex2_target : fall_through;
  assign o_upd_mispredict = dir_miss || tgt_miss;

  // Link write-back
  assign o_wr_valid = i_ex2_valid && i_ex2_wr_valid;
  assign o_wr_rd    = i_ex2_rd;
  assign o_wr_data  = i_ex2_link_data;

  // Only a taken jump writes a link
  always_comb begin
    a_wr_from_jump: assert (!o_wr_valid || (o_upd_taken && !o_upd_is_cond))
      else $error("link write for x%0d from a branch that is not a taken jump", o_wr_rd);
  end

endmodule

// File: hdl/bru_target_unit.sv
`timescale 1ns/1ps
// Branch target and link value in ex1, side by side with the condition unit
// Registers target, link data and prediction info into ex2

`include "bru_cfg.svh"

module bru_target_unit (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_ex1_valid,
  input  bru_pkg::imm_kind_t  i_ex1_imm_kind,
  input  logic                i_ex1_is_cond,
  input  logic                i_ex1_wr_rd,
  input  bru_pkg::regidx_t    i_ex1_rd,
  input  bru_pkg::vaddr_t     i_ex1_pc,
  input  bru_pkg::inst_t      i_ex1_inst,
  input  logic                i_ex1_is_rvc,
  input  bru_pkg::xlen_t      i_ex1_rs1_data,
  input  logic                i_ex1_pred_taken,
  input  bru_pkg::vaddr_t     i_ex1_pred_target,
  output logic                o_ex2_valid,
  output bru_pkg::vaddr_t     o_ex2_target,
  output bru_pkg::xlen_t      o_ex2_link_data,
  output bru_pkg::vaddr_t     o_ex2_pc,
  output logic                o_ex2_is_rvc,
  output logic                o_ex2_is_cond,
  output logic                o_ex2_wr_valid,
  output bru_pkg::regidx_t    o_ex2_rd,
  output logic                o_ex2_pred_taken,
  output bru_pkg::vaddr_t     o_ex2_pred_target
);
  import bru_pkg::*;

  vaddr_t offset_sb;
  vaddr_t offset_uj;
  vaddr_t offset_i;
  vaddr_t jalr_sum;
  vaddr_t target;
  xlen_t  pc_ext;
  xlen_t  link_data;

  // Immediates, sign extended to the address width
  assign offset_sb = {{(`BRU_VADDR_W-13){i_ex1_inst[31]}}, i_ex1_inst[31], i_ex1_inst[7],
                      i_ex1_inst[30:25], i_ex1_inst[11:8], 1'b0};
  assign offset_uj = {{(`BRU_VADDR_W-21){i_ex1_inst[31]}}, i_ex1_inst[31],
                      i_ex1_inst[19:12], i_ex1_inst[20], i_ex1_inst[30:21], 1'b0};
  assign offset_i  = {{(`BRU_VADDR_W-12){i_ex1_inst[31]}}, i_ex1_inst[31:20]};

  assign jalr_sum = i_ex1_rs1_data[`BRU_VADDR_W-1:0] + offset_i;

  always_comb begin
    case (i_ex1_imm_kind)
      IMM_SB:  target = i_ex1_pc + offset_sb;
      IMM_UJ:  target = i_ex1_pc + offset_uj;
      IMM_I:   target = {jalr_sum[`BRU_VADDR_W-1:1], 1'b0};  // JALR drops bit 0
      default: target = i_ex1_pc;
    endcase
  end

  // Return address
  assign pc_ext    = {{(`BRU_XLEN-`BRU_VADDR_W){i_ex1_pc[`BRU_VADDR_W-1]}}, i_ex1_pc};
  assign link_data = pc_ext + (i_ex1_is_rvc ? xlen_t'(2) : xlen_t'(4));

  // ---------------------------------------------------------------------------
  // Ex2 registers
  // ---------------------------------------------------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_valid <= 1'b0;
    end else begin
      o_ex2_valid <= i_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex2_target      <= target;
    o_ex2_link_data   <= link_data;
    o_ex2_pc          <= i_ex1_pc;
    o_ex2_is_rvc      <= i_ex1_is_rvc;
    o_ex2_is_cond     <= i_ex1_is_cond;
    o_ex2_wr_valid    <= i_ex1_wr_rd && (i_ex1_rd != '0);  // x0 is never written
    o_ex2_rd          <= i_ex1_rd;
    o_ex2_pred_taken  <= i_ex1_pred_taken;
    o_ex2_pred_target <= i_ex1_pred_target;
  end

  // Holds only while the fetch side hands in even pcs
  a_target_even: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ex2_valid |-> !o_ex2_target[0])
    else $error("odd branch target %h for pc %h", o_ex2_target, o_ex2_pc);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the branch pipeline testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
  --top-module bru_tb -o bru_sim > build.log 2>&1 \
  && ./obj_dir/bru_sim > "$LOG" 2>&1 \
  || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -q "TEST RESULT: FAIL" "$LOG" && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST RESULT: PASS" "$LOG" || { echo "No result found in $LOG"; exit 1; }

echo "Simulation passed"
exit 0

// File: verif/bru_tb.sv
`timescale 1ns/1ps
// Testbench for the branch execution pipeline
// Replays the trace file with random idle gaps and checks every branch update

module bru_tb;
  import bru_pkg::*;

  localparam string TRACE_FILE    = "verif/bru_trace.txt";
  localparam int    DRAIN_TIMEOUT = 50;   // Cycles
  localparam int    LATENCY       = 2;

  logic    i_clk;
  logic    i_reset_n;
  logic    i_issue_valid;
  vaddr_t  i_issue_pc;
  inst_t   i_issue_inst;
  logic    i_issue_is_rvc;
  xlen_t   i_issue_rs1_data;
  xlen_t   i_issue_rs2_data;
  logic    i_issue_pred_taken;
  vaddr_t  i_issue_pred_target;
  logic    o_upd_valid;
  vaddr_t  o_upd_pc;
  logic    o_upd_is_cond;
  logic    o_upd_taken;
  vaddr_t  o_upd_target;
  logic    o_upd_mispredict;
  logic    o_wr_valid;
  regidx_t o_wr_rd;
  xlen_t   o_wr_data;

  // Expectations, oldest first
  string   q_name[$];
  int      q_edge[$];      // Cycle the issue is driven in
  vaddr_t  q_pc[$];
  inst_t   q_inst[$];
  logic    q_taken[$];
  vaddr_t  q_target[$];
  logic    q_mispredict[$];
  logic    q_wr_valid[$];
  xlen_t   q_wr_data[$];

  int          cycle_cnt    = 0;
  int          error_count  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          parse_errors = 0;
  int          issued       = 0;
  logic [31:0] rng_state    = 32'h8435_bf8a;

  bru_pipe dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t: %s %s is %0h, expected %0h", $time, test, what, got, expected);
      error_count++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------

  task automatic drop_oldest();
    q_name.delete(0);
    q_edge.delete(0);
    q_pc.delete(0);
    q_inst.delete(0);
    q_taken.delete(0);
    q_target.delete(0);
    q_mispredict.delete(0);
    q_wr_valid.delete(0);
    q_wr_data.delete(0);
  endtask

  task automatic compare_update();
    string name;
    inst_t inst;
    int    errs_before;
    name        = q_name[0];
    inst        = q_inst[0];
    errs_before = error_count;
    check_value(name, "latency", 64'(cycle_cnt - q_edge[0]), 64'(LATENCY));
    check_value(name, "pc", 64'(o_upd_pc), 64'(q_pc[0]));
    check_value(name, "is_cond", 64'(o_upd_is_cond), 64'(inst[6:0] == 7'b1100011));
    check_value(name, "taken", 64'(o_upd_taken), 64'(q_taken[0]));
    check_value(name, "target", 64'(o_upd_target), 64'(q_target[0]));
    check_value(name, "mispredict", 64'(o_upd_mispredict), 64'(q_mispredict[0]));
    check_value(name, "wr_valid", 64'(o_wr_valid), 64'(q_wr_valid[0]));
    if (q_wr_valid[0]) begin
      check_value(name, "wr_rd", 64'(o_wr_rd), 64'(inst[11:7]));
      check_value(name, "wr_data", o_wr_data, q_wr_data[0]);
    end
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed", name);
    end
    drop_oldest();
  endtask

  // Sample away from the rising edge
  always @(negedge i_clk) begin
    if (!i_reset_n || q_name.size() == 0) begin
      if (o_upd_valid || o_wr_valid) begin
        $display("Update or write-back at %0t with no branch in flight", $time);
        error_count++;
      end
    end else if (o_upd_valid) begin
      compare_update();
    end else if (cycle_cnt >= q_edge[0] + LATENCY) begin
      $display("No update for test %s at %0t, two cycles after its issue", q_name[0], $time);
      error_count++;
      tests_run++;
      tests_failed++;
      drop_oldest();
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  task automatic drive_issue(input vaddr_t pc, input inst_t inst, input logic rvc,
                             input xlen_t rs1, input xlen_t rs2,
                             input logic pred_taken, input vaddr_t pred_target);
    @(posedge i_clk);
    #1;
    i_issue_valid       = 1'b1;
    i_issue_pc          = pc;
    i_issue_inst        = inst;
    i_issue_is_rvc      = rvc;
    i_issue_rs1_data    = rs1;
    i_issue_rs2_data    = rs2;
    i_issue_pred_taken  = pred_taken;
    i_issue_pred_target = pred_target;
  endtask

  task automatic drive_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge i_clk);
      #1;
      i_issue_valid = 1'b0;
    end
  endtask

  task automatic run_trace(input int fd);
    string  line;
    string  name;
    vaddr_t pc;
    vaddr_t pred_target;
    vaddr_t exp_target;
    inst_t  inst;
    logic   rvc;
    logic   pred_taken;
    logic   exp_taken;
    logic   exp_misp;
    logic   exp_wr_valid;
    xlen_t  rs1;
    xlen_t  rs2;
    xlen_t  exp_wr_data;
    int     fields;
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", name, pc, inst,
                         rvc, rs1, rs2, pred_taken, pred_target, exp_taken, exp_target,
                         exp_misp, exp_wr_valid, exp_wr_data);
        if (fields != 13) begin
          $display("Malformed trace line: %s", line);
          parse_errors++;
        end else begin
          drive_issue(pc, inst, rvc, rs1, rs2, pred_taken, pred_target);
          q_name.push_back(name);
          q_edge.push_back(cycle_cnt);
          q_pc.push_back(pc);
          q_inst.push_back(inst);
          q_taken.push_back(exp_taken);
          q_target.push_back(exp_target);
          q_mispredict.push_back(exp_misp);
          q_wr_valid.push_back(exp_wr_valid);
          q_wr_data.push_back(exp_wr_data);
          issued++;
          rng_state = next_random(rng_state);
          drive_idle(int'(rng_state % 32'd3));  // 0 to 2 bubbles
        end
      end
    end
    drive_idle(1);
  endtask

  task automatic wait_drain(output logic ok);
    int waited;
    waited = 0;
    while (q_name.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge i_clk);
      waited++;
    end
    ok = (q_name.size() == 0);
    if (!ok) begin
      $display("Timed out after %0d cycles with %0d updates outstanding",
               DRAIN_TIMEOUT, q_name.size());
    end
    repeat (4) @(posedge i_clk);  // Catch late strays
  endtask

  initial begin
    int   fd;
    logic drain_ok;
    i_reset_n           = 1'b0;
    i_issue_valid       = 1'b0;
    i_issue_pc          = '0;
    i_issue_inst        = '0;
    i_issue_is_rvc      = 1'b0;
    i_issue_rs1_data    = '0;
    i_issue_rs2_data    = '0;
    i_issue_pred_taken  = 1'b0;
    i_issue_pred_target = '0;
    repeat (2) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open trace file %s", TRACE_FILE);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      run_trace(fd);
      $fclose(fd);
      wait_drain(drain_ok);
      $display("issued %0d, tests %0d, failed %0d, errors %0d, bad lines %0d",
               issued, tests_run, tests_failed, error_count, parse_errors);
      if (drain_ok && issued > 0 && tests_run == issued && tests_failed == 0 &&
          error_count == 0 && parse_errors == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: verif/bru_trace.txt
# name pc inst is_rvc rs1 rs2 pred_taken pred_target, then expected taken target mispredict
# wr_valid wr_data; all values hex, wr_data only counts when wr_valid is 1
beq_eq_taken       1000 00208863 0 5 5 1 1010 1 1010 0 0 0
beq_ne_fall        1100 00208863 0 5 6 0 0 0 1104 0 0 0
bne_back_taken     1200 fe209ce3 0 1 2 1 11f8 1 11f8 0 0 0
bne_eq_misp        1300 00209863 0 deadbeefcafef00d deadbeefcafef00d 1 1310 0 1304 1 0 0
blt_neg_taken      1400 0020c863 0 ffffffffffffffff 1 0 0 1 1410 1 0 0
blt_pos_fall       1500 fe20cce3 0 1 ffffffffffffffff 0 0 0 1504 0 0 0
bge_equal_taken    1600 0020d863 0 8000000000000000 8000000000000000 1 1610 1 1610 0 0 0
bge_neg_fall       1700 fe20dce3 0 8000000000000000 0 0 0 0 1704 0 0 0
bltu_large_fall    1800 0020e863 0 ffffffffffffffff 1 1 1810 0 1804 1 0 0
bltu_small_taken   1900 fe20ece3 0 1 ffffffffffffffff 1 18f8 1 18f8 0 0 0
bgeu_large_badtgt  1a00 0020f863 0 8000000000000000 7fffffffffffffff 1 1a20 1 1a10 1 0 0
bgeu_small_fall    1b00 fe20fce3 0 0 1 0 0 0 1b04 0 0 0
beq_rvc_fall       1c02 00208863 1 0 1 0 0 0 1c04 0 0 0
bne_rvc_taken      1d06 fe209ce3 1 0 3 1 1cfe 1 1cfe 0 0 0
jal_link           2000 100000ef 0 0 0 1 2100 1 2100 0 1 2004
jal_back_rvc       2202 ff1ff0ef 1 0 0 1 21f2 1 21f2 0 1 2204
jal_x0_pred_nt     2300 1000006f 0 0 0 0 0 1 2400 1 0 0
jal_bad_tgt        2400 100000ef 0 0 0 1 2404 1 2500 1 1 2404
jalr_link          2500 008280e7 0 3000 0 1 3008 1 3008 0 1 2504
jalr_odd_clear     2600 003280e7 0 2000 0 1 2002 1 2002 0 1 2604
jalr_neg_badtgt    2700 ffc280e7 0 3001 0 1 2ffd 1 2ffc 1 1 2704
jalr_ret_x0        2800 00008067 0 4000 0 1 4000 1 4000 0 0 0
jalr_rvc           2902 008280e7 1 5000 0 1 5008 1 5008 0 1 2904
jal_high_pc        7ffffff000 100000ef 0 0 0 1 7ffffff100 1 7ffffff100 0 1 fffffffffffff004
jal_x5_pred_nt     2a00 100002ef 0 0 0 0 0 1 2b00 1 1 2a04
blt_both_neg       2b00 0020c863 0 fffffffffffffffe ffffffffffffffff 1 2b10 1 2b10 0 0 0
bgeu_equal_misp    2c00 fe20fce3 0 ffffffffffffffff ffffffffffffffff 0 0 1 2bf8 1 0 0
bltu_equal_fall    2d00 0020e863 0 1234 1234 0 0 0 2d04 0 0 0
bne_rvc_fall_misp  2e02 00209863 1 7 7 1 2e12 0 2e04 1 0 0
jalr_big_rs1       2f00 008280e7 0 ffffffffffff0000 0 1 7fffff0008 1 7fffff0008 0 1 2f04
beq_neg_taken      3000 fe208ce3 0 ffffffffffffffff ffffffffffffffff 1 2ff8 1 2ff8 0 0 0
bge_max_badtgt     3100 fe20dce3 0 7fffffffffffffff 8000000000000000 1 3104 1 30f8 1 0 0
jal_x0_rvc         3202 ff1ff06f 1 0 0 1 31f2 1 31f2 0 0 0
jalr_x0_rvc        3302 00008067 1 6002 0 1 6002 1 6002 0 0 0
